// ==== verilog/vcoal_consts.svh ====
// Sizing constants for the vector store coalescer.
// Include this wherever lane counts or block geometry are needed;
// the package builds its vector types from these values.

`ifndef VCOAL_CONSTS_SVH
`define VCOAL_CONSTS_SVH

// number of vector lanes (the lane walk is written for exactly four)
`define VCOAL_LANES 4

// address and data word width
`define VCOAL_WORD_BITS 32

// words in one data cache block
`define VCOAL_BLOCK_WORDS 4

// byte offset bits inside a block (log2 of 16 bytes)
`define VCOAL_OFS_BITS 4

`endif

// ==== verilog/vcoal_pkg.sv ====
// Shared types for the vector store coalescer.
// Modules import this with a wildcard in their body and use scoped
// names for the types that appear on their ports.

`default_nettype none

`include "vcoal_consts.svh"

package vcoal_pkg;

    typedef logic [`VCOAL_WORD_BITS-1:0]                        word_t;
    typedef logic [`VCOAL_LANES-1:0]                            lane_vec_t;
    typedef logic [$clog2(`VCOAL_LANES)-1:0]                    lane_idx_t;
    typedef logic [`VCOAL_WORD_BITS-`VCOAL_OFS_BITS-1:0]        block_tag_t;
    typedef logic [`VCOAL_BLOCK_WORDS*`VCOAL_WORD_BITS-1:0]     block_data_t;
    typedef logic [`VCOAL_BLOCK_WORDS*(`VCOAL_WORD_BITS/8)-1:0] block_sel_t;

    // same encoding order as the vector unit's sew field
    typedef enum logic [1:0] {EEW8 = 2'd0, EEW16 = 2'd1, EEW32 = 2'd2} eew_t;

    typedef enum logic [1:0] {ST_IDLE, ST_CAPTURE, ST_ISSUE, ST_DONE} ctrl_state_t;

    typedef struct packed {
        word_t                       base;
        word_t                       stride;
        logic                        indexed;
        eew_t                        eew;
        lane_vec_t                   mask;
        word_t [`VCOAL_LANES-1:0]    idx_addr;
        word_t [`VCOAL_LANES-1:0]    data;
    } vstore_req_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        word_t       adr;
        block_sel_t  sel;
        block_data_t dat;
    } wb_out_t;

endpackage

`default_nettype wire

// ==== verilog/vcoal_req_capture.sv ====
// Holds the accepted vector store micro-op for the whole walk.
// Loads on capture_en and presents the per-lane byte addresses,
// lane data, element width and lane mask to the rest of the datapath.

`default_nettype none

`include "vcoal_consts.svh"

module vcoal_req_capture (
    input  wire logic                                   CLK,
    input  wire logic                                   nRST,
    input  wire logic                                   capture_en,
    input  wire vcoal_pkg::vstore_req_t                 req,
    output vcoal_pkg::word_t [`VCOAL_LANES-1:0]         lane_addr,
    output vcoal_pkg::word_t [`VCOAL_LANES-1:0]         lane_data,
    output vcoal_pkg::eew_t                             eew,
    output vcoal_pkg::lane_vec_t                        mask
);

    import vcoal_pkg::*;

    word_t                    base_q;
    word_t                    stride_q;
    logic                     indexed_q;
    eew_t                     eew_q;
    lane_vec_t                mask_q;
    word_t [`VCOAL_LANES-1:0] idx_q;
    word_t [`VCOAL_LANES-1:0] data_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mask_q <= '0;
        end else if (capture_en) begin
            mask_q <= req.mask;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture_en) begin
            base_q    <= req.base;
            stride_q  <= req.stride;
            indexed_q <= req.indexed;
            eew_q     <= req.eew;
            idx_q     <= req.idx_addr;
            data_q    <= req.data;
        end
    end

    // strided lanes sit at base + n * stride and indexed lanes bring their own
    always_comb begin
        for (int i = 0; i < `VCOAL_LANES; i++) begin
            lane_addr[i] = indexed_q ? idx_q[i] : base_q + word_t'(i) * stride_q;
        end
    end

    assign lane_data = data_q;
    assign eew       = eew_q;
    assign mask      = mask_q;

endmodule

`default_nettype wire

// ==== verilog/vcoal_block_matcher.sv ====
// Tracks which lanes still have to be written and forms the next group.
// The leader is the lowest pending lane; every pending lane in the same
// cache block joins it. retire clears the lanes of an acknowledged group.

`default_nettype none

`include "vcoal_consts.svh"

module vcoal_block_matcher (
    input  wire logic                                   CLK,
    input  wire logic                                   nRST,
    input  wire logic                                   capture_en,
    input  wire vcoal_pkg::lane_vec_t                   mask,
    input  wire vcoal_pkg::word_t [`VCOAL_LANES-1:0]    lane_addr,
    input  wire vcoal_pkg::lane_vec_t                   retire,
    output logic                                        any_pending,
    output vcoal_pkg::lane_vec_t                        group,
    output vcoal_pkg::block_tag_t                       leader_tag
);

    import vcoal_pkg::*;

    lane_vec_t retired_q;
    lane_vec_t pending;
    lane_idx_t leader;

    // retired lanes are wiped on capture so pending follows the new mask
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            retired_q <= '0;
        end else if (capture_en) begin
            retired_q <= '0;
        end else begin
            retired_q <= retired_q | retire;
        end
    end

    assign pending = mask & ~retired_q;

    // scan from the top so the lowest pending lane ends up as leader
    always_comb begin
        leader = '0;
        for (int i = `VCOAL_LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                leader = lane_idx_t'(i);
            end
        end
    end

    assign leader_tag = lane_addr[leader][`VCOAL_WORD_BITS-1:`VCOAL_OFS_BITS];

    always_comb begin
        for (int i = 0; i < `VCOAL_LANES; i++) begin
            group[i] = pending[i] &&
                       (lane_addr[i][`VCOAL_WORD_BITS-1:`VCOAL_OFS_BITS] == leader_tag);
        end
    end

    // lanes that will still be waiting once the current group retires
    assign any_pending = |(pending & ~group);

endmodule

`default_nettype wire

// ==== verilog/vcoal_store_merge.sv ====
// Builds the block write for the current group.
// Each grouped lane drops its low 1, 2 or 4 data bytes at its byte
// offset in the block and raises the matching byte selects.
// Purely combinational; lanes are applied in ascending order so a higher
// lane overwrites any byte it shares with a lower one.

`default_nettype none

`include "vcoal_consts.svh"

module vcoal_store_merge (
    input  wire vcoal_pkg::lane_vec_t                   group,
    input  wire vcoal_pkg::word_t [`VCOAL_LANES-1:0]    lane_addr,
    input  wire vcoal_pkg::word_t [`VCOAL_LANES-1:0]    lane_data,
    input  wire vcoal_pkg::eew_t                        eew,
    output vcoal_pkg::block_sel_t                       sel,
    output vcoal_pkg::block_data_t                      dat
);

    import vcoal_pkg::*;

    localparam int BLOCK_BYTES = `VCOAL_BLOCK_WORDS * (`VCOAL_WORD_BITS / 8);

    logic [`VCOAL_OFS_BITS-1:0] ofs;
    block_sel_t                 lane_sel;
    block_data_t                lane_dat;

    always_comb begin
        sel      = '0;
        dat      = '0;
        ofs      = '0;
        lane_sel = '0;
        lane_dat = '0;

        for (int i = 0; i < `VCOAL_LANES; i++) begin
            if (group[i]) begin
                ofs = lane_addr[i][`VCOAL_OFS_BITS-1:0];

                // the element is repeated across the block and the select picks its slot
                case (eew)
                    EEW8: begin
                        lane_sel = block_sel_t'(1) << ofs;
                        lane_dat = {BLOCK_BYTES{lane_data[i][7:0]}};
                    end
                    EEW16: begin
                        lane_sel = block_sel_t'(2'b11) << {ofs[`VCOAL_OFS_BITS-1:1], 1'b0};
                        lane_dat = {(BLOCK_BYTES / 2){lane_data[i][15:0]}};
                    end
                    default: begin
                        lane_sel = block_sel_t'(4'hf) << {ofs[`VCOAL_OFS_BITS-1:2], 2'b00};
                        lane_dat = {`VCOAL_BLOCK_WORDS{lane_data[i]}};
                    end
                endcase

                for (int b = 0; b < BLOCK_BYTES; b++) begin
                    if (lane_sel[b]) begin
                        dat[b*8 +: 8] = lane_dat[b*8 +: 8];
                    end
                end
                sel = sel | lane_sel;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vcoal_ctrl.sv ====
// Sequencing FSM of the store coalescer.
// Accepts a micro-op while idle, spends one cycle in capture, then keeps
// a Wishbone classic write cycle open until every group has been acked.
// Each ack retires the current group; done pulses once at the end.

`default_nettype none

module vcoal_ctrl (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire logic                   req_valid,
    input  wire logic                   any_pending,
    input  wire vcoal_pkg::lane_vec_t   group,
    input  wire logic                   wb_ack,
    output logic                        capture_en,
    output logic                        busy,
    output logic                        done,
    output logic                        cyc,
    output logic                        stb,
    output logic                        we,
    output vcoal_pkg::lane_vec_t        retire
);

    import vcoal_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        issuing;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid) begin
                    state_d = ST_CAPTURE;
                end
            end
            ST_CAPTURE: begin
                // an empty group here means the mask had no active lanes
                state_d = (|group) ? ST_ISSUE : ST_DONE;
            end
            ST_ISSUE: begin
                if (wb_ack) begin
                    state_d = any_pending ? ST_ISSUE : ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign issuing    = (state_q == ST_ISSUE);

    // requests are only looked at while idle
    assign capture_en = (state_q == ST_IDLE) && req_valid;
    assign busy       = (state_q != ST_IDLE);
    assign done       = (state_q == ST_DONE);

    // every access is a store so we follows the bus cycle
    assign cyc        = issuing;
    assign stb        = issuing;
    assign we         = issuing;

    assign retire     = (issuing && wb_ack) ? group : '0;

endmodule

`default_nettype wire

// ==== verilog/vcoal_top.sv ====
// Top level of the vector store coalescer.
// Takes one vector store micro-op per req_valid strobe while busy is low
// and emits one Wishbone classic block write per group of lanes that
// share a cache block.

`default_nettype none

`include "vcoal_consts.svh"

module vcoal_top (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire vcoal_pkg::vstore_req_t req,
    input  wire logic                   req_valid,
    input  wire logic                   wb_ack,
    output vcoal_pkg::wb_out_t          wb,
    output logic                        busy,
    output logic                        done
);

    import vcoal_pkg::*;

    logic                     capture_en;
    logic                     any_pending;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    lane_vec_t                retire;
    lane_vec_t                group;
    lane_vec_t                mask;
    block_tag_t               leader_tag;
    eew_t                     eew;
    word_t [`VCOAL_LANES-1:0] lane_addr;
    word_t [`VCOAL_LANES-1:0] lane_data;
    block_sel_t               sel;
    block_data_t              dat;

    vcoal_ctrl ctrl_i (
        .CLK(CLK), .nRST(nRST), .req_valid(req_valid), .any_pending(any_pending),
        .group(group), .wb_ack(wb_ack), .capture_en(capture_en), .busy(busy),
        .done(done), .cyc(cyc), .stb(stb), .we(we), .retire(retire)
    );

    vcoal_req_capture capture_i (
        .CLK(CLK), .nRST(nRST), .capture_en(capture_en), .req(req),
        .lane_addr(lane_addr), .lane_data(lane_data), .eew(eew), .mask(mask)
    );

    vcoal_block_matcher matcher_i (
        .CLK(CLK), .nRST(nRST), .capture_en(capture_en), .mask(mask),
        .lane_addr(lane_addr), .retire(retire), .any_pending(any_pending),
        .group(group), .leader_tag(leader_tag)
    );

    vcoal_store_merge merge_i (
        .group(group), .lane_addr(lane_addr), .lane_data(lane_data), .eew(eew),
        .sel(sel), .dat(dat)
    );

    // block aligned address from the leader's tag
    always_comb begin
        wb.cyc = cyc;
        wb.stb = stb;
        wb.we  = we;
        wb.adr = {leader_tag, {`VCOAL_OFS_BITS{1'b0}}};
        wb.sel = sel;
        wb.dat = dat;
    end

endmodule

`default_nettype wire

// ==== verif/vcoal_clk_gen.sv ====
// Clock and reset source for the coalescer testbench.
// CLK has a period of 40; nRST stays low for the first five rising
// edges and is released just after the fifth.

`default_nettype none

module vcoal_clk_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        repeat (5) @(posedge CLK);
        #1 nRST = 1'b1;
    end

    always #20 CLK = ~CLK;

endmodule

`default_nettype wire

// ==== verif/vcoal_sva.sv ====
// Wishbone classic protocol checks for the store coalescer.
// Bound into vcoal_top; each rule is a concurrent assertion sampled
// on CLK while reset is released.

`default_nettype none

`include "vcoal_consts.svh"

module vcoal_sva (
    input wire logic               CLK,
    input wire logic               nRST,
    input wire vcoal_pkg::wb_out_t wb,
    input wire logic               wb_ack,
    input wire logic               done
);

    stb_in_cyc: assert property (@(posedge CLK) disable iff (!nRST) wb.stb |-> wb.cyc)
        else $error("stb high outside a bus cycle");

    // an unacked strobe keeps the whole request in place
    hold_until_ack: assert property (@(posedge CLK) disable iff (!nRST)
        (wb.stb && !wb_ack) |=>
            (wb.stb && $stable(wb.adr) && $stable(wb.sel) && $stable(wb.dat)))
        else $error("bus request changed before ack");

    adr_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        wb.stb |-> (wb.adr[`VCOAL_OFS_BITS-1:0] == '0))
        else $error("block address has nonzero offset bits");

    no_done_in_cyc: assert property (@(posedge CLK) disable iff (!nRST) !(done && wb.cyc))
        else $error("done raised during a bus cycle");

endmodule

bind vcoal_top vcoal_sva sva_i (
    .CLK(CLK), .nRST(nRST), .wb(wb), .wb_ack(wb_ack), .done(done)
);

`default_nettype wire

// ==== verif/vcoal_tb.sv ====
// Testbench for the vector store coalescer.
// Applies a table of store micro-ops, acts as a Wishbone classic slave
// with random ack delay and checks every block write and the done pulse
// against the table's expected writes.

`default_nettype none

`include "vcoal_consts.svh"

module vcoal_tb;

    import vcoal_pkg::*;

    localparam int NUM_ENTRIES = 10;
    localparam int MAX_WRITES  = `VCOAL_LANES;
    localparam int BLOCK_BYTES = `VCOAL_BLOCK_WORDS * (`VCOAL_WORD_BITS / 8);
    // entries x 4 writes x 8 cycles per write x clock period
    localparam int TIMEOUT     = NUM_ENTRIES * 4 * 8 * 40;

    logic        CLK;
    logic        nRST;
    vstore_req_t req;
    logic        req_valid;
    logic        wb_ack;
    wb_out_t     wb;
    logic        busy;
    logic        done;

    integer      seed;
    int          errors;
    int          checks;

    vstore_req_t req_tab [NUM_ENTRIES];
    int          exp_cnt [NUM_ENTRIES];
    word_t       exp_adr [NUM_ENTRIES][MAX_WRITES];
    block_sel_t  exp_sel [NUM_ENTRIES][MAX_WRITES];
    block_data_t exp_dat [NUM_ENTRIES][MAX_WRITES];

    vcoal_clk_gen clk_gen_i (.CLK(CLK), .nRST(nRST));

    vcoal_top vcoal_top_i (
        .CLK(CLK), .nRST(nRST), .req(req), .req_valid(req_valid),
        .wb_ack(wb_ack), .wb(wb), .busy(busy), .done(done)
    );

    task automatic set_req(input int e, input word_t base, input word_t stride,
                           input logic indexed, input eew_t eew, input lane_vec_t mask,
                           input word_t [3:0] idx, input word_t [3:0] data);
        req_tab[e].base     = base;
        req_tab[e].stride   = stride;
        req_tab[e].indexed  = indexed;
        req_tab[e].eew      = eew;
        req_tab[e].mask     = mask;
        req_tab[e].idx_addr = idx;
        req_tab[e].data     = data;
        exp_cnt[e]          = 0;
    endtask

    task automatic add_write(input int e, input word_t adr, input block_sel_t sel,
                             input block_data_t dat);
        exp_adr[e][exp_cnt[e]] = adr;
        exp_sel[e][exp_cnt[e]] = sel;
        exp_dat[e][exp_cnt[e]] = dat;
        exp_cnt[e]             = exp_cnt[e] + 1;
    endtask

    // unit stride, large strides, masking, indexed, narrow elements, overlap
    task automatic build_table();
        set_req(0, 32'h1000, 32'd4, 1'b0, EEW32, 4'b1111, '0,
                {32'h44444444, 32'h33333333, 32'h22222222, 32'h11111111});
        add_write(0, 32'h1000, 16'hffff, 128'h44444444_33333333_22222222_11111111);
        set_req(1, 32'h2004, 32'd32, 1'b0, EEW32, 4'b1111, '0,
                {32'hcafe0003, 32'hcafe0002, 32'hcafe0001, 32'hcafe0000});
        add_write(1, 32'h2000, 16'h00f0, 128'h00000000_00000000_cafe0000_00000000);
        add_write(1, 32'h2020, 16'h00f0, 128'h00000000_00000000_cafe0001_00000000);
        add_write(1, 32'h2040, 16'h00f0, 128'h00000000_00000000_cafe0002_00000000);
        add_write(1, 32'h2060, 16'h00f0, 128'h00000000_00000000_cafe0003_00000000);
        set_req(2, 32'h3000, 32'd4, 1'b0, EEW32, 4'b1010, '0,
                {32'h9abcdef0, 32'h0badf00d, 32'h12345678, 32'h0badf00d});
        add_write(2, 32'h3000, 16'hf0f0, 128'h9abcdef0_00000000_12345678_00000000);
        set_req(3, 32'h3100, 32'd4, 1'b0, EEW32, 4'b0000, '0,
                {32'h0badf00d, 32'h0badf00d, 32'h0badf00d, 32'h0badf00d});
        // lanes 0 and 2 share a block and lane 3 is masked off
        set_req(4, 32'h9000, 32'd4, 1'b1, EEW32, 4'b0111,
                {32'h4004, 32'h4000, 32'h5000, 32'h4008},
                {32'h4444dddd, 32'h3333cccc, 32'h2222bbbb, 32'h1111aaaa});
        add_write(4, 32'h4000, 16'h0f0f, 128'h00000000_1111aaaa_00000000_3333cccc);
        add_write(4, 32'h5000, 16'h000f, 128'h00000000_00000000_00000000_2222bbbb);
        set_req(5, 32'h6001, 32'd1, 1'b0, EEW8, 4'b1111, '0,
                {32'hdddddd44, 32'hcccccc33, 32'hbbbbbb22, 32'haaaaaa11});
        add_write(5, 32'h6000, 16'h001e, 128'h00000000_00000000_00000044_33221100);
        set_req(6, 32'h700e, 32'd2, 1'b0, EEW16, 4'b1111, '0,
                {32'hffffdef0, 32'h00009abc, 32'h12345678, 32'hdeadbeef});
        add_write(6, 32'h7000, 16'hc000, 128'hbeef0000_00000000_00000000_00000000);
        add_write(6, 32'h7010, 16'h003f, 128'h00000000_00000000_0000def0_9abc5678);
        // every lane hits the same word so lane 3 must win
        set_req(7, 32'h8008, 32'd0, 1'b0, EEW32, 4'b1111, '0,
                {32'h04040404, 32'h03030303, 32'h02020202, 32'h01010101});
        add_write(7, 32'h8000, 16'h0f00, 128'h00000000_04040404_00000000_00000000);
        set_req(8, 32'ha00c, 32'd16, 1'b0, EEW32, 4'b1101, '0,
                {32'hd3d3d3d3, 32'hc2c2c2c2, 32'hb1b1b1b1, 32'ha0a0a0a0});
        add_write(8, 32'ha000, 16'hf000, 128'ha0a0a0a0_00000000_00000000_00000000);
        add_write(8, 32'ha020, 16'hf000, 128'hc2c2c2c2_00000000_00000000_00000000);
        add_write(8, 32'ha030, 16'hf000, 128'hd3d3d3d3_00000000_00000000_00000000);
        set_req(9, 32'hb00c, 32'd8, 1'b0, EEW8, 4'b1111, '0,
                {32'h000000d4, 32'h000000c3, 32'h000000b2, 32'h000000a1});
        add_write(9, 32'hb000, 16'h1000, 128'h000000a1_00000000_00000000_00000000);
        add_write(9, 32'hb010, 16'h1010, 128'h000000c3_00000000_000000b2_00000000);
        add_write(9, 32'hb020, 16'h0010, 128'h00000000_00000000_000000d4_00000000);
    endtask

    // bytes outside the selects carry no meaning
    function automatic block_data_t byte_mask(input block_sel_t s);
        block_data_t m;
        m = '0;
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            if (s[b]) begin
                m[b*8 +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    task automatic check_write(input int e, input int n);
        checks++;
        if (n >= exp_cnt[e]) begin
            errors++;
            $display("FAIL %0t: entry %0d extra write to %h", $time, e, wb.adr);
        end else begin
            if (!wb.cyc || !wb.we) begin
                errors++;
                $display("FAIL %0t: entry %0d write %0d without cyc or we", $time, e, n);
            end
            if (wb.adr != exp_adr[e][n]) begin
                errors++;
                $display("FAIL %0t: entry %0d write %0d adr %h expected %h",
                         $time, e, n, wb.adr, exp_adr[e][n]);
            end
            if (wb.sel != exp_sel[e][n]) begin
                errors++;
                $display("FAIL %0t: entry %0d write %0d sel %h expected %h",
                         $time, e, n, wb.sel, exp_sel[e][n]);
            end
            if ((wb.dat & byte_mask(exp_sel[e][n])) != exp_dat[e][n]) begin
                errors++;
                $display("FAIL %0t: entry %0d write %0d dat %h expected %h",
                         $time, e, n, wb.dat, exp_dat[e][n]);
            end
        end
    endtask

    // one micro-op from strobe to done with the testbench as bus slave
    task automatic run_entry(input int e);
        int   nwr;
        int   delay;
        logic finished;
        nwr      = 0;
        finished = 1'b0;
        while (busy) begin
            @(posedge CLK);
            #1;
        end
        req       = req_tab[e];
        req_valid = 1'b1;
        @(posedge CLK);
        #1;
        req_valid = 1'b0;
        req       = '0;
        checks++;
        if (!busy || wb.stb) begin
            errors++;
            $display("FAIL %0t: entry %0d not in capture after accept", $time, e);
        end
        while (!finished) begin
            if (done) begin
                finished = 1'b1;
                checks++;
                if (nwr != exp_cnt[e]) begin
                    errors++;
                    $display("FAIL %0t: entry %0d done after %0d writes, expected %0d",
                             $time, e, nwr, exp_cnt[e]);
                end
            end else if (wb.stb) begin
                delay = $random(seed) & 3;
                repeat (delay) begin
                    @(posedge CLK);
                    #1;
                end
                check_write(e, nwr);
                wb_ack = 1'b1;
                @(posedge CLK);
                #1;
                wb_ack = 1'b0;
                nwr++;
                if (nwr == exp_cnt[e]) begin
                    checks++;
                    if (!done || wb.stb) begin
                        errors++;
                        $display("FAIL %0t: entry %0d no done right after last ack", $time, e);
                    end
                end
            end else begin
                @(posedge CLK);
                #1;
            end
        end
        @(posedge CLK);
        #1;
        // done is a single-cycle pulse and the unit is idle again
        checks++;
        if (done || busy) begin
            errors++;
            $display("FAIL %0t: entry %0d done or busy still high after the done pulse",
                     $time, e);
        end
    endtask

    initial begin
        seed      = 32'hefb0;
        errors    = 0;
        checks    = 0;
        req       = '0;
        req_valid = 1'b0;
        wb_ack    = 1'b0;
        build_table();
        @(posedge nRST);
        @(posedge CLK);
        #1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the table was not finished, the DUT seems stuck");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/vcoal_pkg.sv
verilog/vcoal_req_capture.sv
verilog/vcoal_block_matcher.sv
verilog/vcoal_store_merge.sv
verilog/vcoal_ctrl.sv
verilog/vcoal_top.sv
verif/vcoal_clk_gen.sv
verif/vcoal_sva.sv
verif/vcoal_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the coalescer testbench with Verilator and runs it.
# The exit status comes from searching the log for the failure message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module vcoal_tb \
    -Mdir obj_dir -o vcoal_sim && ./obj_dir/vcoal_sim > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
